/* list.f */
+incdir+.
idiv_pkg.sv
idiv_ctrl_if.sv
idiv_datapath.sv
idiv_controller.sv
idiv_top.sv
idiv_checker.sv
idiv_tb.sv

/* Makefile */
TOP = idiv_tb
LOG = sim.log

all: run

obj_dir/V$(TOP): list.f $(wildcard *.sv) $(wildcard *.svh)
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)
	verilator --lint-only +incdir+. idiv_pkg.sv idiv_ctrl_if.sv idiv_datapath.sv \
		idiv_controller.sv idiv_top.sv --top-module idiv_top

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean

/* idiv_tb.sv */
//--------------------------------------------------------------------
// self-checking testbench for idiv_top with results taken in order
// run length is bounded by a cycle limit from the test count
//--------------------------------------------------------------------
`include "idiv_macros.svh"

module idiv_tb;

  typedef idiv_pkg::word_t word_t;

  localparam int W           = `IDIV_WIDTH;
  localparam int N_DIRECTED  = 14;
  localparam int N_RANDOM    = 400;
  localparam int N_TESTS     = N_DIRECTED + N_RANDOM;
  localparam int MAX_YUMI    = 5;
  localparam int CYCLE_LIMIT = N_TESTS * (`IDIV_LATENCY + MAX_YUMI + 4) + 100;

  localparam word_t MIN_WORD = {1'b1, {(W-1){1'b0}}};
  localparam word_t ONES     = '1;

  // DUT inputs
  logic  clk_i        = 1'b0;
  logic  arst_n_i     = 1'b0;
  logic  v_i          = 1'b0;
  word_t dividend_i   = '0;
  word_t divisor_i    = '0;
  logic  signed_div_i = 1'b0;
  logic  yumi_i       = 1'b0;

  // DUT outputs
  logic  ready_o;
  logic  v_o;
  word_t quotient_o;
  word_t remainder_o;

  // bookkeeping
  int    cycle_cnt  = 0;
  int    errors     = 0;
  int    checks     = 0;
  int    results    = 0;
  int    accept_cycle = 0;
  int    yumi_wait  = 0;
  logic  v_prev     = 1'b0;
  logic  hold_valid = 1'b0;
  word_t hold_quo;
  word_t hold_rem;

  // separate generator states for stimulus and yumi delays
  logic [31:0] stim_rng = 32'h4ec71417;
  logic [31:0] yumi_rng = 32'h4ec71417;

  // requests accepted and not yet handed back
  word_t dvd_pend[$];
  word_t dvs_pend[$];
  logic  sgn_pend[$];

  idiv_top UUT (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .v_i          (v_i),
    .ready_o      (ready_o),
    .dividend_i   (dividend_i),
    .divisor_i    (divisor_i),
    .signed_div_i (signed_div_i),
    .v_o          (v_o),
    .quotient_o   (quotient_o),
    .remainder_o  (remainder_o),
    .yumi_i       (yumi_i)
  );

  always #10 clk_i = ~clk_i;

  //------------------------------------------------------------------
  // helpers
  //------------------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // truncating division with the remainder taking the dividend sign
  function automatic logic [2*W-1:0] ref_divide(input word_t dvd, input word_t dvs,
                                                input logic sgn);
    word_t mag_n;
    word_t mag_d;
    word_t q;
    word_t r;
    if (dvs == '0) begin
      return {ONES, dvd};
    end
    if (!sgn) begin
      return {dvd / dvs, dvd % dvs};
    end
    // signed overflow wraps back to the dividend
    if (dvd == MIN_WORD && dvs == ONES) begin
      return {dvd, word_t'(0)};
    end
    mag_n = dvd[W-1] ? -dvd : dvd;
    mag_d = dvs[W-1] ? -dvs : dvs;
    q = mag_n / mag_d;
    r = mag_n % mag_d;
    if (dvd[W-1] ^ dvs[W-1]) begin
      q = -q;
    end
    if (dvd[W-1]) begin
      r = -r;
    end
    return {q, r};
  endfunction

  task automatic check_value(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic next_word(output word_t w);
    logic [31:0] hi;
    stim_rng = lcg_next(stim_rng);
    hi = stim_rng;
    stim_rng = lcg_next(stim_rng);
    w = word_t'({hi, stim_rng});
  endtask

  // called on a rising edge and returns on the accepting edge
  task automatic send_request(input word_t dvd, input word_t dvs, input logic sgn);
    v_i          <= 1'b1;
    dividend_i   <= dvd;
    divisor_i    <= dvs;
    signed_div_i <= sgn;
    do begin
      @(posedge clk_i);
    end while (!ready_o);
  endtask

  //------------------------------------------------------------------
  // stimulus
  //------------------------------------------------------------------
  initial begin
    word_t dvd;
    word_t dvs;
    logic  sgn;
    repeat (5) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);
    check_value("ready_o", word_t'(ready_o), word_t'(1));
    check_value("v_o", word_t'(v_o), word_t'(0));
    // zero divisor, overflow and small dividends
    send_request(word_t'(100), word_t'(0), 1'b0);
    send_request(word_t'(100), word_t'(0), 1'b1);
    send_request(word_t'(-100), word_t'(0), 1'b1);
    send_request(MIN_WORD, ONES, 1'b1);
    send_request(MIN_WORD, ONES, 1'b0);
    send_request(word_t'(5), word_t'(7), 1'b0);
    send_request(word_t'(-5), word_t'(7), 1'b1);
    // all four sign combinations
    send_request(word_t'(7), word_t'(2), 1'b1);
    send_request(word_t'(-7), word_t'(2), 1'b1);
    send_request(word_t'(7), word_t'(-2), 1'b1);
    send_request(word_t'(-7), word_t'(-2), 1'b1);
    send_request(ONES, word_t'(1), 1'b0);
    send_request(word_t'(0), word_t'(5), 1'b1);
    send_request(MIN_WORD, word_t'(1), 1'b1);
    for (int i = 0; i < N_RANDOM; i++) begin
      next_word(dvd);
      next_word(dvs);
      stim_rng = lcg_next(stim_rng);
      sgn = stim_rng[15];
      // narrow the divisor so quotients spread over all sizes
      dvs = dvs >> (stim_rng[31:16] % W);
      if (stim_rng[5] && sgn) begin
        dvs = -dvs;
      end
      // short idle gap now and then
      if (stim_rng[11:8] == 4'd0) begin
        v_i <= 1'b0;
        repeat (2) @(posedge clk_i);
      end
      send_request(dvd, dvs, sgn);
    end
    v_i <= 1'b0;
    while (results < N_TESTS) begin
      @(posedge clk_i);
    end
    $display("checks: %0d, errors: %0d, results: %0d", checks, errors, results);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // consumer with random delay keeps yumi inside v_o
  always @(posedge clk_i) begin
    if (yumi_i) begin
      yumi_i <= 1'b0;
    end else if (v_o) begin
      if (yumi_wait == 0) begin
        yumi_i <= 1'b1;
      end else begin
        yumi_wait <= yumi_wait - 1;
      end
    end else begin
      yumi_rng = lcg_next(yumi_rng);
      yumi_wait <= int'(yumi_rng[31:16] % (MAX_YUMI + 1));
    end
  end

  //------------------------------------------------------------------
  // compare on values sampled before the edge updates them
  //------------------------------------------------------------------
  always @(posedge clk_i) begin
    logic [2*W-1:0] exp;
    if (arst_n_i) begin
      if (v_i && ready_o) begin
        dvd_pend.push_back(dividend_i);
        dvs_pend.push_back(divisor_i);
        sgn_pend.push_back(signed_div_i);
        accept_cycle = cycle_cnt;
      end
      if (v_o && !v_prev) begin
        check_value("latency", word_t'(cycle_cnt - accept_cycle), word_t'(`IDIV_LATENCY));
      end
      if (v_o) begin
        check_value("ready_o", word_t'(ready_o), word_t'(0));
        // results hold while the consumer waits
        if (hold_valid) begin
          check_value("quotient_o held", quotient_o, hold_quo);
          check_value("remainder_o held", remainder_o, hold_rem);
        end
        hold_quo   = quotient_o;
        hold_rem   = remainder_o;
        hold_valid = !yumi_i;
        if (yumi_i) begin
          if (dvd_pend.size() == 0) begin
            errors++;
            $display("result handed off with no request pending");
          end else begin
            exp = ref_divide(dvd_pend.pop_front(), dvs_pend.pop_front(),
                             sgn_pend.pop_front());
            check_value("quotient_o", quotient_o, exp[2*W-1:W]);
            check_value("remainder_o", remainder_o, exp[W-1:0]);
            results++;
          end
        end
      end else begin
        hold_valid = 1'b0;
      end
      v_prev = v_o;
    end
  end

  // run limit
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("run timed out after %0d cycles with %0d of %0d results taken",
               cycle_cnt, results, N_TESTS);
      $display("Test failures found");
      $finish;
    end
  end

endmodule

/* idiv_checker.sv */
//--------------------------------------------------------------------
// handshake and latency assertions, bound to idiv_top
//--------------------------------------------------------------------
`include "idiv_macros.svh"

module idiv_checker (
  input logic            clk_i,
  input logic            arst_n_i,
  input logic            v_i,
  input logic            ready_o,
  input logic            v_o,
  input logic            yumi_i,
  input idiv_pkg::word_t quotient_o,
  input idiv_pkg::word_t remainder_o
);

  // idle and done are separate states
  a_ready_v_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(ready_o && v_o))
    else $error("ready_o and v_o high together");

  // consumer may only take a valid result
  a_yumi_in_v: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    yumi_i |-> v_o)
    else $error("yumi_i high while v_o low");

  // back-pressure keeps the result steady
  a_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (v_o && !yumi_i) |=> (v_o && $stable(quotient_o) && $stable(remainder_o)))
    else $error("result changed before hand-off");

  // fixed latency from the accepting edge
  a_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (v_i && ready_o) |-> ##(`IDIV_LATENCY) $rose(v_o))
    else $error("v_o did not rise at the fixed latency");

endmodule

bind idiv_top idiv_checker u_checker (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .v_i         (v_i),
  .ready_o     (ready_o),
  .v_o         (v_o),
  .yumi_i      (yumi_i),
  .quotient_o  (quotient_o),
  .remainder_o (remainder_o)
);

/* idiv_top.sv */
//--------------------------------------------------------------------
// iterative divider top, valid/ready request and valid/yumi result
// yumi_i may only be high while v_o is high
//--------------------------------------------------------------------
`include "idiv_macros.svh"

module idiv_top (
  input  logic            clk_i,
  input  logic            arst_n_i,

  // request side
  input  logic            v_i,
  output logic            ready_o,
  input  idiv_pkg::word_t dividend_i,
  input  idiv_pkg::word_t divisor_i,
  input  logic            signed_div_i,

  // result side
  output logic            v_o,
  output idiv_pkg::word_t quotient_o,
  output idiv_pkg::word_t remainder_o,
  input  logic            yumi_i
);

  // controls and status between the two halves
  idiv_ctrl_if ctrl_if ();

  idiv_controller u_controller (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .v_i      (v_i),
    .ready_o  (ready_o),
    .yumi_i   (yumi_i),
    .v_o      (v_o),
    .ctrl     (ctrl_if.ctrl)
  );

  idiv_datapath u_datapath (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .dividend_i   (dividend_i),
    .divisor_i    (divisor_i),
    .signed_div_i (signed_div_i),
    .ctrl         (ctrl_if.dp),
    .quotient_o   (quotient_o),
    .remainder_o  (remainder_o)
  );

endmodule

/* idiv_controller.sv */
//--------------------------------------------------------------------
// divider controller, one request in flight, fixed latency
// every sign step takes its cycle even when nothing needs negating
//--------------------------------------------------------------------
`include "idiv_macros.svh"

module idiv_controller (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     v_i,
  output logic     ready_o,
  input  logic     yumi_i,
  output logic     v_o,
  idiv_ctrl_if.ctrl ctrl
);

  idiv_pkg::idiv_state_e state_q;
  idiv_pkg::idiv_state_e state_d;
  idiv_pkg::iter_cnt_t   iter_q;

  logic iter_last;
  logic neg_divisor;

  // sign of the previous adder result, picks add or subtract
  logic neg_last_q;
  // result signs, latched while A and C still hold the raw operands
  logic q_neg_q;
  logic r_neg_q;

  // W+1 iterations, index 0 .. W
  assign iter_last   = (iter_q == idiv_pkg::iter_cnt_t'(`IDIV_WIDTH));
  assign neg_divisor = ctrl.signed_r & ctrl.a_neg;

  assign ready_o = (state_q == idiv_pkg::IDLE);
  assign v_o     = (state_q == idiv_pkg::DONE);

  //------------------------------------------------------------------
  // state, counter and sign flags
  //------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= idiv_pkg::IDLE;
      iter_q     <= '0;
      neg_last_q <= 1'b0;
      q_neg_q    <= 1'b0;
      r_neg_q    <= 1'b0;
    end else begin
      state_q    <= state_d;
      neg_last_q <= ctrl.sum_neg;
      if (state_q == idiv_pkg::ITERATE && !iter_last) begin
        iter_q <= iter_q + 1'b1;
      end else begin
        iter_q <= '0;
      end
      if (state_q == idiv_pkg::NEG_DIVISOR) begin
        // remainder follows the dividend sign
        r_neg_q <= ctrl.signed_r & ctrl.c_neg;
        // zero divisor keeps the all-ones quotient unsigned
        q_neg_q <= ctrl.signed_r & (ctrl.a_neg ^ ctrl.c_neg) & ~ctrl.divisor_zero;
      end
    end
  end

  //------------------------------------------------------------------
  // next state and datapath controls
  //------------------------------------------------------------------
  always_comb begin
    state_d      = state_q;
    ctrl.latch_o = 1'b0;
    ctrl.a_sel   = 1'b0;
    ctrl.a_ld    = 1'b0;
    ctrl.a_inv   = 1'b0;
    ctrl.a_clr_n = 1'b1;
    ctrl.b_sel   = `IDIV_SEL_SUM;
    ctrl.b_ld    = 1'b0;
    ctrl.b_inv   = 1'b0;
    ctrl.b_clr_n = 1'b1;
    ctrl.c_sel   = `IDIV_SEL_SUM;
    ctrl.c_ld    = 1'b0;
    ctrl.cin     = 1'b0;

    unique case (state_q)
      idiv_pkg::IDLE: begin
        // loads only on an accepting edge
        if (v_i) begin
          ctrl.latch_o = 1'b1;
          ctrl.a_sel   = 1'b1;
          ctrl.a_ld    = 1'b1;
          ctrl.c_sel   = `IDIV_SEL_OPND;
          ctrl.c_ld    = 1'b1;
          state_d      = idiv_pkg::NEG_DIVISOR;
        end
      end
      idiv_pkg::NEG_DIVISOR: begin
        // A <= -A or A + 0, B picks up the dividend from C
        ctrl.a_inv   = neg_divisor;
        ctrl.cin     = neg_divisor;
        ctrl.b_clr_n = 1'b0;
        ctrl.a_ld    = 1'b1;
        ctrl.b_sel   = `IDIV_SEL_OPND;
        ctrl.b_ld    = 1'b1;
        state_d      = idiv_pkg::NEG_DIVIDEND;
      end
      idiv_pkg::NEG_DIVIDEND: begin
        // C <= -B or B
        ctrl.a_clr_n = 1'b0;
        ctrl.b_inv   = r_neg_q;
        ctrl.cin     = r_neg_q;
        ctrl.c_ld    = 1'b1;
        state_d      = idiv_pkg::SHIFT;
      end
      idiv_pkg::SHIFT: begin
        // adder gives zero, B gets the dividend msb
        ctrl.a_clr_n = 1'b0;
        ctrl.b_clr_n = 1'b0;
        ctrl.b_sel   = `IDIV_SEL_SHIFT;
        ctrl.b_ld    = 1'b1;
        ctrl.c_sel   = `IDIV_SEL_SHIFT;
        ctrl.c_ld    = 1'b1;
        state_d      = idiv_pkg::ITERATE;
      end
      idiv_pkg::ITERATE: begin
        // subtract after a positive result, add after a negative one
        ctrl.a_inv = ~neg_last_q;
        ctrl.cin   = ~neg_last_q;
        // last step keeps the remainder unshifted
        ctrl.b_sel = iter_last ? `IDIV_SEL_SUM : `IDIV_SEL_SHIFT;
        ctrl.b_ld  = 1'b1;
        ctrl.c_sel = `IDIV_SEL_SHIFT;
        ctrl.c_ld  = 1'b1;
        if (iter_last) begin
          state_d = idiv_pkg::REPAIR;
        end
      end
      idiv_pkg::REPAIR: begin
        // negative remainder gets the divisor added back
        ctrl.a_clr_n = neg_last_q;
        ctrl.b_ld    = 1'b1;
        state_d      = idiv_pkg::NEG_REM;
      end
      idiv_pkg::NEG_REM: begin
        // A <= +/-B, quotient moves from C into B
        ctrl.a_clr_n = 1'b0;
        ctrl.b_inv   = r_neg_q;
        ctrl.cin     = r_neg_q;
        ctrl.a_ld    = 1'b1;
        ctrl.b_sel   = `IDIV_SEL_OPND;
        ctrl.b_ld    = 1'b1;
        state_d      = idiv_pkg::NEG_QUO;
      end
      idiv_pkg::NEG_QUO: begin
        // C <= +/-B
        ctrl.a_clr_n = 1'b0;
        ctrl.b_inv   = q_neg_q;
        ctrl.cin     = q_neg_q;
        ctrl.c_ld    = 1'b1;
        state_d      = idiv_pkg::DONE;
      end
      idiv_pkg::DONE: begin
        // hold results until the consumer takes them
        if (yumi_i) begin
          state_d = idiv_pkg::IDLE;
        end
      end
      default: begin
        state_d = idiv_pkg::IDLE;
      end
    endcase
  end

endmodule

/* idiv_datapath.sv */
//--------------------------------------------------------------------
// divider datapath: operand registers A, B, C and one shared adder
// operands are sampled only on the edge where latch_o is high
//--------------------------------------------------------------------
`include "idiv_macros.svh"

module idiv_datapath (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  idiv_pkg::word_t dividend_i,
  input  idiv_pkg::word_t divisor_i,
  input  logic            signed_div_i,
  idiv_ctrl_if.dp         ctrl,
  output idiv_pkg::word_t quotient_o,
  output idiv_pkg::word_t remainder_o
);

  // operand registers
  idiv_pkg::ext_word_t a_q;
  idiv_pkg::ext_word_t b_q;
  idiv_pkg::ext_word_t c_q;

  // next values
  idiv_pkg::ext_word_t a_d;
  idiv_pkg::ext_word_t b_d;
  idiv_pkg::ext_word_t c_d;

  // adder inputs after invert and clear
  idiv_pkg::ext_word_t add_a;
  idiv_pkg::ext_word_t add_b;
  idiv_pkg::ext_word_t sum;

  // shift paths for one iteration
  idiv_pkg::ext_word_t b_shift;
  idiv_pkg::ext_word_t c_shift;

  logic divisor_ext;
  logic dividend_ext;
  logic signed_q;

  //------------------------------------------------------------------
  // input sign extension
  //------------------------------------------------------------------
  // extra msb is the sign only for a signed request
  assign divisor_ext  = signed_div_i & divisor_i[`IDIV_WIDTH-1];
  assign dividend_ext = signed_div_i & dividend_i[`IDIV_WIDTH-1];

  //------------------------------------------------------------------
  // adder with invert and clear on both inputs
  //------------------------------------------------------------------
  // inv plus cin gives subtract or negate
  assign add_a = (a_q ^ {`IDIV_EXT_WIDTH{ctrl.a_inv}}) & {`IDIV_EXT_WIDTH{ctrl.a_clr_n}};
  assign add_b = (b_q ^ {`IDIV_EXT_WIDTH{ctrl.b_inv}}) & {`IDIV_EXT_WIDTH{ctrl.b_clr_n}};

  // carry out of the top bit is dropped
  assign sum = add_a + add_b + idiv_pkg::ext_word_t'(ctrl.cin);

  //------------------------------------------------------------------
  // input selection
  //------------------------------------------------------------------
  // partial remainder moves up, next dividend bit comes in from C
  assign b_shift = {sum[`IDIV_WIDTH-1:0], c_q[`IDIV_WIDTH]};

  // new quotient bit is set when the partial remainder stays positive
  assign c_shift = {c_q[`IDIV_WIDTH-1:0], ~sum[`IDIV_WIDTH]};

  assign a_d = ctrl.a_sel ? {divisor_ext, divisor_i} : sum;

  // one-hot and-or muxes
  assign b_d = ({`IDIV_EXT_WIDTH{ctrl.b_sel[0]}} & c_q)
             | ({`IDIV_EXT_WIDTH{ctrl.b_sel[1]}} & sum)
             | ({`IDIV_EXT_WIDTH{ctrl.b_sel[2]}} & b_shift);

  assign c_d = ({`IDIV_EXT_WIDTH{ctrl.c_sel[0]}} & {dividend_ext, dividend_i})
             | ({`IDIV_EXT_WIDTH{ctrl.c_sel[1]}} & sum)
             | ({`IDIV_EXT_WIDTH{ctrl.c_sel[2]}} & c_shift);

  //------------------------------------------------------------------
  // registers
  //------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (ctrl.a_ld) begin
      a_q <= a_d;
    end
    if (ctrl.b_ld) begin
      b_q <= b_d;
    end
    if (ctrl.c_ld) begin
      c_q <= c_d;
    end
  end

  // signed flag of the request in flight
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      signed_q <= 1'b0;
    end else if (ctrl.latch_o) begin
      signed_q <= signed_div_i;
    end
  end

  //------------------------------------------------------------------
  // status and results
  //------------------------------------------------------------------
  // A holds the divisor until NEG_REM
  assign ctrl.divisor_zero = ~(|a_q);
  assign ctrl.signed_r     = signed_q;
  assign ctrl.sum_neg      = sum[`IDIV_WIDTH];
  assign ctrl.a_neg        = a_q[`IDIV_WIDTH];
  assign ctrl.c_neg        = c_q[`IDIV_WIDTH];

  assign quotient_o  = c_q[`IDIV_WIDTH-1:0];
  assign remainder_o = a_q[`IDIV_WIDTH-1:0];

endmodule

/* idiv_ctrl_if.sv */
//--------------------------------------------------------------------
// datapath controls and status between controller and datapath
// all signals are combinational within one cycle
//--------------------------------------------------------------------
interface idiv_ctrl_if;

  // capture sign flag and operands on the accepting edge
  logic       latch_o;

  // register A: divisor, later remainder
  logic       a_sel;
  logic       a_ld;
  logic       a_inv;
  logic       a_clr_n;

  // register B: partial remainder, one-hot select
  logic [2:0] b_sel;
  logic       b_ld;
  logic       b_inv;
  logic       b_clr_n;

  // register C: dividend, later quotient
  logic [2:0] c_sel;
  logic       c_ld;

  // adder carry-in, set for subtract and negate
  logic       cin;

  // status back to the controller
  logic       divisor_zero;
  logic       signed_r;
  logic       sum_neg;
  logic       a_neg;
  logic       c_neg;

  modport ctrl (
    output latch_o, a_sel, a_ld, a_inv, a_clr_n,
    output b_sel, b_ld, b_inv, b_clr_n, c_sel, c_ld, cin,
    input  divisor_zero, signed_r, sum_neg, a_neg, c_neg
  );

  modport dp (
    input  latch_o, a_sel, a_ld, a_inv, a_clr_n,
    input  b_sel, b_ld, b_inv, b_clr_n, c_sel, c_ld, cin,
    output divisor_zero, signed_r, sum_neg, a_neg, c_neg
  );

endinterface

/* idiv_pkg.sv */
//--------------------------------------------------------------------
// divider word types and controller states
// sizes follow IDIV_WIDTH from the macro header
//--------------------------------------------------------------------
`include "idiv_macros.svh"

package idiv_pkg;

  // operands, quotient and remainder
  typedef logic [`IDIV_WIDTH-1:0] word_t;

  // sign-extended operand registers and adder
  typedef logic [`IDIV_EXT_WIDTH-1:0] ext_word_t;

  // iteration index, holds 0 .. W
  typedef logic [$clog2(`IDIV_WIDTH + 1)-1:0] iter_cnt_t;

  //------------------------------------------------------------------
  // controller states, one per cycle except ITERATE
  //------------------------------------------------------------------
  typedef enum logic [3:0] {
    IDLE,
    NEG_DIVISOR,
    NEG_DIVIDEND,
    SHIFT,
    ITERATE,
    REPAIR,
    NEG_REM,
    NEG_QUO,
    DONE
  } idiv_state_e;

endpackage

/* idiv_macros.svh */
//--------------------------------------------------------------------
// divider width and latency, shared by RTL and testbench
// widths below 4 are not supported
//--------------------------------------------------------------------
`ifndef IDIV_MACROS_SVH
`define IDIV_MACROS_SVH

// operand and result width
`define IDIV_WIDTH 32

// operand registers carry one extra sign bit
`define IDIV_EXT_WIDTH (`IDIV_WIDTH + 1)

// v_o is high in the (W+8)th cycle after the accepting cycle
`define IDIV_LATENCY (`IDIV_WIDTH + 8)

// one-hot selects for the B and C register inputs
// opnd picks C for B, the dividend for C
`define IDIV_SEL_OPND  3'b001
`define IDIV_SEL_SUM   3'b010
`define IDIV_SEL_SHIFT 3'b100

`endif
